/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ---------------------------------------------------------------------------
// core-wide sizes
// ---------------------------------------------------------------------------

// data and pc width
`define XLEN 32

// byte address width of the shared memory port
`define MEM_ADDR_W 17

// architectural registers x0..x31
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* source/cpu_pkg.sv */
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [4:0]             reg_idx_t;

    // {instr[30], funct3}
    typedef logic [3:0]             func_code_t;

    // alu operation class
    typedef enum logic [2:0] {
        binary      = 3'd0,
        imm_binary  = 3'd1,
        mem_addr    = 3'd2,
        branch_cond = 3'd3,
        imm         = 3'd4,
        pc_based    = 3'd5,
        alu_nop     = 3'd6
    } alu_op_e;

    // memory request, same encoding as the mem_signal port
    typedef enum logic [1:0] {
        mem_nop   = 2'b00,
        read_data = 2'b01,
        write     = 2'b10,
        read_inst = 2'b11
    } mem_op_e;

    typedef enum logic [1:0] {
        not_branch  = 2'b00,
        jump_reg    = 2'b01,
        conditional = 2'b10,
        jump_pc     = 2'b11
    } branch_e;

    typedef enum logic [1:0] {
        wb_nop       = 2'b00,
        arith        = 2'b01,
        mem_to_reg   = 2'b10,
        increased_pc = 2'b11
    } wb_sel_e;

endpackage

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder
    import cpu_pkg::*;
(
    input  word_t      instr,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output func_code_t func_code,
    output alu_op_e    alu_op,
    output mem_op_e    mem_op,
    output branch_e    branch,
    output wb_sel_e    wb_sel,
    output logic       fmt_i,
    output logic       fmt_s,
    output logic       fmt_b,
    output logic       fmt_u,
    output logic       fmt_j
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // slli/srli/srai keep bit 30 like register ops, other immediates drop it
    assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign func_code = {instr[30] & ((opcode == OP_REG) || is_shift), funct3};

    always_comb begin
        // anything not matched below is a full no-op
        alu_op = alu_nop;
        mem_op = mem_nop;
        branch = not_branch;
        wb_sel = wb_nop;
        fmt_i  = 1'b0;
        fmt_s  = 1'b0;
        fmt_b  = 1'b0;
        fmt_u  = 1'b0;
        fmt_j  = 1'b0;
        case (opcode)
            OP_REG: begin
                alu_op = binary;
                wb_sel = arith;
            end
            OP_IMM: begin
                alu_op = imm_binary;
                wb_sel = arith;
                fmt_i  = 1'b1;
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    alu_op = mem_addr;
                    mem_op = read_data;
                    wb_sel = mem_to_reg;
                    fmt_i  = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    alu_op = mem_addr;
                    mem_op = write;
                    fmt_s  = 1'b1;
                end
            end
            OP_BRANCH: begin
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    alu_op = branch_cond;
                    branch = conditional;
                    fmt_b  = 1'b1;
                end
            end
            OP_LUI: begin
                alu_op = imm;
                wb_sel = arith;
                fmt_u  = 1'b1;
            end
            OP_AUIPC: begin
                alu_op = pc_based;
                wb_sel = arith;
                fmt_u  = 1'b1;
            end
            OP_JAL: begin
                branch = jump_pc;
                wb_sel = increased_pc;
                fmt_j  = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    alu_op = mem_addr;
                    branch = jump_reg;
                    wb_sel = increased_pc;
                    fmt_i  = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* source/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import cpu_pkg::*;
(
    input  word_t instr,
    input  logic  fmt_i,
    input  logic  fmt_s,
    input  logic  fmt_b,
    input  logic  fmt_u,
    input  logic  fmt_j,
    output word_t imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        if (fmt_i) begin
            imm = {{20{sign}}, instr[31:20]};
        end else if (fmt_s) begin
            imm = {{20{sign}}, instr[31:25], instr[11:7]};
        end else if (fmt_b) begin
            imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end else if (fmt_u) begin
            imm = {instr[31:12], 12'b0};
        end else if (fmt_j) begin
            imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        end else begin
            // register-register ops carry no immediate
            imm = '0;
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  word_t      imm,
    input  word_t      pc,
    input  alu_op_e    alu_op,
    input  func_code_t func_code,
    output word_t      result,
    output logic       equal
);

    word_t op_b;
    word_t arith_res;

    // second operand is rs2 only for register-register ops
    assign op_b  = (alu_op == binary) ? rs2_val : imm;
    assign equal = (rs1_val == rs2_val);

    always_comb begin
        case (func_code[2:0])
            3'b000: arith_res = func_code[3] ? rs1_val - op_b : rs1_val + op_b;
            3'b001: arith_res = rs1_val << op_b[4:0];
            3'b010: arith_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
            3'b011: arith_res = {31'b0, rs1_val < op_b};
            3'b100: arith_res = rs1_val ^ op_b;
            3'b101: arith_res = func_code[3] ? word_t'($signed(rs1_val) >>> op_b[4:0])
                                             : rs1_val >> op_b[4:0];
            3'b110: arith_res = rs1_val | op_b;
            default: arith_res = rs1_val & op_b;
        endcase
    end

    always_comb begin
        case (alu_op)
            binary, imm_binary: result = arith_res;
            mem_addr:           result = rs1_val + imm;
            cpu_pkg::imm:       result = imm;
            pc_based:           result = pc + imm;
            // branch compare goes out on equal
            default:            result = '0;
        endcase
    end

    // pc leaves reset together with the latched controls
    always_comb begin
        if (!$isunknown(pc)) begin
            assert final (!$isunknown(alu_op))
                else $error("alu: alu_op unknown while the core runs");
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

`include "cpu_params.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs1_val,
    output word_t    rs2_val
);

    word_t regs [`NUM_REGS];

    // x0 is never written, so it reads back zero
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != 5'd0)) begin
            regs[rd] <= wr_data;
        end
    end

endmodule

/* source/next_pc.sv */
`timescale 1ns/1ps

module next_pc
    import cpu_pkg::*;
(
    input  word_t      pc,
    input  word_t      result,
    input  word_t      imm,
    input  branch_e    branch,
    input  func_code_t func_code,
    input  logic       equal,
    output word_t      pc_next
);

    logic taken;

    // beq on funct3 000, bne on 001
    assign taken = (func_code[2:0] == 3'b000) ? equal : !equal;

    always_comb begin
        case (branch)
            conditional: pc_next = taken ? pc + imm : pc + 32'd4;
            jump_pc:     pc_next = pc + imm;
            jump_reg:    pc_next = result & ~32'd1;
            default:     pc_next = pc + 32'd4;
        endcase
    end

endmodule

/* source/stage_sequencer.sv */
`timescale 1ns/1ps

`include "cpu_params.svh"

module stage_sequencer
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rdy_in,
    input  word_t      mem_read_data,
    input  logic       mem_vis_finished,
    input  reg_idx_t   rd,
    input  func_code_t func_code,
    input  alu_op_e    alu_op,
    input  mem_op_e    mem_op,
    input  branch_e    branch,
    input  wb_sel_e    wb_sel,
    input  word_t      imm,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  word_t      alu_result,
    input  logic       alu_equal,
    input  word_t      pc_next,
    output word_t      instr,
    output word_t      pc,
    output word_t      op_rs1_val,
    output word_t      op_rs2_val,
    output word_t      op_imm,
    output alu_op_e    op_alu_op,
    output func_code_t op_func_code,
    output branch_e    op_branch,
    output word_t      ex_result,
    output logic       ex_equal,
    output logic       rf_wr_en,
    output reg_idx_t   rf_rd,
    output word_t      rf_wr_data,
    output mem_addr_t  mem_addr,
    output mem_op_e    mem_signal,
    output word_t      mem_write_data
);

    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_execute,
        s_memory,
        s_writeback
    } stage_e;

    stage_e  state;
    mem_op_e mem_op_q;
    wb_sel_e wb_sel_q;
    word_t   wb_data;

    // ------------------------------------------------------------------------
    // stage state and stage registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= s_fetch;
            pc           <= `RESET_PC;
            op_alu_op    <= alu_nop;
            op_func_code <= '0;
            op_branch    <= not_branch;
            mem_op_q     <= mem_nop;
            wb_sel_q     <= wb_nop;
            rf_rd        <= '0;
        end else if (rdy_in) begin
            case (state)
                s_fetch: begin
                    if (mem_vis_finished) begin
                        instr <= mem_read_data;
                        state <= s_decode;
                    end
                end
                s_decode: begin
                    op_rs1_val   <= rs1_val;
                    op_rs2_val   <= rs2_val;
                    op_imm       <= imm;
                    op_alu_op    <= alu_op;
                    op_func_code <= func_code;
                    op_branch    <= branch;
                    mem_op_q     <= mem_op;
                    wb_sel_q     <= wb_sel;
                    rf_rd        <= rd;
                    state        <= s_execute;
                end
                s_execute: begin
                    ex_result <= alu_result;
                    ex_equal  <= alu_equal;
                    state     <= s_memory;
                end
                s_memory: begin
                    // non-memory ops pass straight through
                    if (mem_op_q == mem_nop || mem_vis_finished) begin
                        rf_wr_data <= wb_data;
                        pc         <= pc_next;
                        state      <= s_writeback;
                    end
                end
                default: begin
                    state <= s_fetch;
                end
            endcase
        end
    end

    // writeback value sampled while pc still holds this instruction
    always_comb begin
        case (wb_sel_q)
            mem_to_reg:   wb_data = mem_read_data;
            increased_pc: wb_data = pc + 32'd4;
            default:      wb_data = ex_result;
        endcase
    end

    assign rf_wr_en = (state == s_writeback) && (wb_sel_q != wb_nop) && rdy_in;

    // ------------------------------------------------------------------------
    // shared memory port
    // ------------------------------------------------------------------------
    always_comb begin
        case (state)
            s_fetch: begin
                // no fetch request while reset is held
                mem_signal = rst ? mem_nop : read_inst;
                mem_addr   = pc[`MEM_ADDR_W-1:0];
            end
            s_memory: begin
                mem_signal = mem_op_q;
                mem_addr   = ex_result[`MEM_ADDR_W-1:0];
            end
            default: begin
                mem_signal = mem_nop;
                mem_addr   = pc[`MEM_ADDR_W-1:0];
            end
        endcase
    end

    assign mem_write_data = op_rs2_val;

    // request held until a finished strobe is accepted
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_signal != mem_nop && !(mem_vis_finished && rdy_in))
            |=> ($stable(mem_signal) && $stable(mem_addr)))
        else $error("memory request changed while pending");

    a_nop_in_reset: assert property (@(posedge clk) rst |-> (mem_signal == mem_nop))
        else $error("memory request issued during reset");

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy_in,
    input  word_t     mem_read_data,
    input  logic      mem_vis_finished,
    output word_t     mem_write_data,
    output mem_addr_t mem_addr,
    output mem_op_e   mem_signal
);

    // decode side
    word_t      instr;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    func_code_t func_code;
    alu_op_e    alu_op;
    mem_op_e    mem_op;
    branch_e    branch;
    wb_sel_e    wb_sel;
    logic       fmt_i;
    logic       fmt_s;
    logic       fmt_b;
    logic       fmt_u;
    logic       fmt_j;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;

    // latched operands and results
    word_t      pc;
    word_t      op_rs1_val;
    word_t      op_rs2_val;
    word_t      op_imm;
    alu_op_e    op_alu_op;
    func_code_t op_func_code;
    branch_e    op_branch;
    word_t      alu_result;
    logic       alu_equal;
    word_t      ex_result;
    logic       ex_equal;
    word_t      pc_next;
    logic       rf_wr_en;
    reg_idx_t   rf_rd;
    word_t      rf_wr_data;

    decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .func_code(func_code),
        .alu_op(alu_op), .mem_op(mem_op), .branch(branch), .wb_sel(wb_sel),
        .fmt_i(fmt_i), .fmt_s(fmt_s), .fmt_b(fmt_b), .fmt_u(fmt_u), .fmt_j(fmt_j)
    );

    imm_gen u_imm_gen (
        .instr(instr), .fmt_i(fmt_i), .fmt_s(fmt_s), .fmt_b(fmt_b),
        .fmt_u(fmt_u), .fmt_j(fmt_j), .imm(imm)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rf_rd),
        .wr_en(rf_wr_en), .wr_data(rf_wr_data), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    alu u_alu (
        .rs1_val(op_rs1_val), .rs2_val(op_rs2_val), .imm(op_imm), .pc(pc),
        .alu_op(op_alu_op), .func_code(op_func_code),
        .result(alu_result), .equal(alu_equal)
    );

    next_pc u_next_pc (
        .pc(pc), .result(ex_result), .imm(op_imm), .branch(op_branch),
        .func_code(op_func_code), .equal(ex_equal), .pc_next(pc_next)
    );

    stage_sequencer u_stage_sequencer (
        .clk(clk), .rst(rst), .rdy_in(rdy_in),
        .mem_read_data(mem_read_data), .mem_vis_finished(mem_vis_finished),
        .rd(rd), .func_code(func_code), .alu_op(alu_op), .mem_op(mem_op),
        .branch(branch), .wb_sel(wb_sel), .imm(imm),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_result(alu_result), .alu_equal(alu_equal), .pc_next(pc_next),
        .instr(instr), .pc(pc),
        .op_rs1_val(op_rs1_val), .op_rs2_val(op_rs2_val), .op_imm(op_imm),
        .op_alu_op(op_alu_op), .op_func_code(op_func_code), .op_branch(op_branch),
        .ex_result(ex_result), .ex_equal(ex_equal),
        .rf_wr_en(rf_wr_en), .rf_rd(rf_rd), .rf_wr_data(rf_wr_data),
        .mem_addr(mem_addr), .mem_signal(mem_signal), .mem_write_data(mem_write_data)
    );

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/1ps

`include "cpu_params.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int          PROG_WORDS  = 256;
    localparam int          NUM_FETCHES = 400;
    localparam int          WAIT_LIMIT  = 64;
    localparam int          MEM_WORDS   = 1 << (`MEM_ADDR_W - 2);
    localparam int unsigned SEED        = 32'h0023_42ea;

    localparam int T_RESET   = 0;
    localparam int T_SEQ     = 1;
    localparam int T_JUMP    = 2;
    localparam int T_LOAD    = 3;
    localparam int T_STORE   = 4;
    localparam int T_HOLD    = 5;
    localparam int NUM_TESTS = 6;

    logic      clk;
    logic      rst;
    logic      rdy_in;
    word_t     mem_read_data;
    logic      mem_vis_finished;
    word_t     mem_write_data;
    mem_addr_t mem_addr;
    mem_op_e   mem_signal;

    // memory seen by the DUT and the ISA model state
    word_t       mem [0:MEM_WORDS-1];
    word_t       model_mem [0:MEM_WORDS-1];
    word_t       model_regs [0:`NUM_REGS-1];
    word_t       model_pc;
    int          checks [0:NUM_TESTS-1];
    int          errors [0:NUM_TESTS-1];
    logic        timed_out;
    int unsigned pause_left;

    cpu_top dut (
        .clk(clk),
        .rst(rst),
        .rdy_in(rdy_in),
        .mem_read_data(mem_read_data),
        .mem_vis_finished(mem_vis_finished),
        .mem_write_data(mem_write_data),
        .mem_addr(mem_addr),
        .mem_signal(mem_signal)
    );

    always #5 clk = ~clk;

    // short random pauses of 1 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            rdy_in     <= 1'b1;
            pause_left <= 0;
        end else if (pause_left != 0) begin
            pause_left <= pause_left - 1;
            rdy_in     <= (pause_left == 1);
        end else if ($urandom_range(9, 0) == 0) begin
            pause_left <= $urandom_range(3, 1);
            rdy_in     <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // program generation and ISA model
    // ------------------------------------------------------------------------
    function automatic string test_label(input int t);
        case (t)
            T_RESET: return "reset_and_first_fetch";
            T_SEQ:   return "sequential_fetch";
            T_JUMP:  return "branch_jump_targets";
            T_LOAD:  return "load_requests";
            T_STORE: return "store_requests";
            default: return "hold_and_no_repeat";
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t random_instr(input int idx);
        int unsigned kind;
        int          tgt;
        word_t       r;
        word_t       off;
        word_t       jt;
        word_t       dofs;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] i12;
        r    = $urandom;
        kind = $urandom_range(15, 0);
        tgt  = $urandom_range(PROG_WORDS - 1, 0);
        rd   = r[11:7];
        f3   = r[14:12];
        alt  = r[30] & ((f3 == 3'b000) || (f3 == 3'b101));
        i12  = r[31:20];
        // data words sit right above the program
        dofs = 32'h400 + 4 * $urandom_range(255, 0);
        // last word loops back to the start
        if (idx == PROG_WORDS - 1) begin
            kind = 14;
            tgt  = 0;
            rd   = 5'd0;
        end
        off = word_t'((tgt - idx) * 4);
        jt  = word_t'(tgt * 4);
        case (kind)
            0, 1, 2: return {1'b0, alt, 5'b0, r[24:15], f3, rd, 7'b0110011};
            3, 4, 5: begin
                if (f3 == 3'b001) begin
                    i12 = {7'b0, r[24:20]};
                end
                if (f3 == 3'b101) begin
                    i12 = {1'b0, alt, 5'b0, r[24:20]};
                end
                return {i12, r[19:15], f3, rd, 7'b0010011};
            end
            6:       return {r[31:12], rd, 7'b0110111};
            7:       return {r[31:12], rd, 7'b0010111};
            8, 9:    return {dofs[11:0], 5'd0, 3'b010, rd, 7'b0000011};
            10, 11:  return {dofs[11:5], r[24:20], 5'd0, 3'b010, dofs[4:0], 7'b0100011};
            12, 13:  return {off[12], off[10:5], r[24:15], 2'b00, r[12], off[4:1], off[11],
                             7'b1100011};
            14:      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            default: return {jt[11:0], 5'd0, 3'b000, rd, 7'b1100111};
        endcase
    endfunction

    // steps one instruction and returns the data request it causes
    task automatic model_step(input word_t ins, output mem_op_e op, output mem_addr_t addr,
                              output word_t wdata);
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      ii;
        word_t      ea;
        word_t      res;
        word_t      pc_n;
        logic       wr;
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        ii    = {{20{ins[31]}}, ins[31:20]};
        op    = mem_nop;
        addr  = '0;
        wdata = '0;
        res   = '0;
        wr    = 1'b1;
        pc_n  = model_pc + 32'd4;
        case (ins[6:0])
            7'b0110011: res = alu_ref(f3, ins[30], a, b);
            7'b0010011: res = alu_ref(f3, ins[30] && (f3 == 3'b101), a, ii);
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010111: res = model_pc + {ins[31:12], 12'b0};
            7'b0000011: begin
                ea   = a + ii;
                op   = read_data;
                addr = ea[`MEM_ADDR_W-1:0];
                res  = model_mem[ea[`MEM_ADDR_W-1:2]];
            end
            7'b0100011: begin
                ea    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                op    = write;
                addr  = ea[`MEM_ADDR_W-1:0];
                wdata = b;
                wr    = 1'b0;
                model_mem[ea[`MEM_ADDR_W-1:2]] = b;
            end
            7'b1100011: begin
                wr = 1'b0;
                // beq taken on equal, bne on not equal
                if ((f3 == 3'b000) == (a == b)) begin
                    pc_n = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                       ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res  = model_pc + 32'd4;
                pc_n = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                   ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res  = model_pc + 32'd4;
                pc_n = (a + ii) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        model_pc = pc_n;
    endtask

    // ------------------------------------------------------------------------
    // compare tasks and the memory responder
    // ------------------------------------------------------------------------
    task automatic compare_op(input int t, input string name, input mem_op_e got,
                              input mem_op_e exp);
        checks[t]++;
        if (got !== exp) begin
            errors[t]++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic compare_addr(input int t, input string name, input mem_addr_t got,
                                input mem_addr_t exp);
        checks[t]++;
        if (got !== exp) begin
            errors[t]++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_word(input int t, input string name, input word_t got,
                                input word_t exp);
        checks[t]++;
        if (got !== exp) begin
            errors[t]++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_held(input mem_op_e op, input mem_addr_t addr, input word_t wdata);
        compare_op(T_HOLD, "mem_signal (held)", mem_signal, op);
        compare_addr(T_HOLD, "mem_addr (held)", mem_addr, addr);
        compare_word(T_HOLD, "mem_write_data (held)", mem_write_data, wdata);
    endtask

    // waits for one request, checks it and answers after 0 to 3 cycles
    task automatic serve_access(input int t, input mem_op_e exp_op, input mem_addr_t exp_addr,
                                input word_t exp_wdata);
        int        cycles;
        int        delay;
        mem_op_e   held_op;
        mem_addr_t held_addr;
        word_t     held_wdata;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (mem_signal == mem_nop && cycles < WAIT_LIMIT);
        if (mem_signal == mem_nop) begin
            $display("Timeout at %0t: the core made no memory request in %0d cycles",
                     $time, WAIT_LIMIT);
            errors[t]++;
            timed_out = 1'b1;
            return;
        end
        compare_op(t, "mem_signal", mem_signal, exp_op);
        compare_addr(t, "mem_addr", mem_addr, exp_addr);
        if (exp_op == write) begin
            compare_word(t, "mem_write_data", mem_write_data, exp_wdata);
        end
        held_op    = mem_signal;
        held_addr  = mem_addr;
        held_wdata = mem_write_data;
        delay      = $urandom_range(3, 0);
        repeat (delay) begin
            @(posedge clk);
            check_held(held_op, held_addr, held_wdata);
        end
        mem_vis_finished <= 1'b1;
        if (held_op != write) begin
            mem_read_data <= mem[held_addr[`MEM_ADDR_W-1:2]];
        end
        // strobe stays up until the core is not paused
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_held(held_op, held_addr, held_wdata);
        end while (!rdy_in && cycles < WAIT_LIMIT);
        mem_vis_finished <= 1'b0;
        mem_read_data    <= $urandom;
        if (!rdy_in) begin
            $display("Timeout at %0t: the finished strobe was never accepted", $time);
            errors[T_HOLD]++;
            timed_out = 1'b1;
            return;
        end
        if (held_op == write) begin
            mem[held_addr[`MEM_ADDR_W-1:2]] = held_wdata;
        end
        @(posedge clk);
        compare_op(T_HOLD, "mem_signal after finish", mem_signal, mem_nop);
    endtask

    task automatic report_test(input int t);
        $display("%s: %s, checks %0d, errors %0d", test_label(t),
                 (errors[t] == 0) ? "pass" : "fail", checks[t], errors[t]);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        word_t     ins;
        mem_op_e   op;
        mem_addr_t addr;
        word_t     wdata;
        int        fetches;
        int        tot_chk;
        int        tot_err;
        logic      prev_jump;
        void'($urandom(SEED));
        clk              = 1'b0;
        rst              = 1'b1;
        rdy_in           = 1'b1;
        mem_read_data    = '0;
        mem_vis_finished = 1'b0;
        timed_out        = 1'b0;
        prev_jump        = 1'b0;
        fetches          = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]       = (word_t'(i) * 32'h9e37_79b9) ^ 32'h0023_42ea;
            model_mem[i] = mem[i];
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            mem[i]       = random_instr(i);
            model_mem[i] = mem[i];
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_pc = `RESET_PC;

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i > 0) begin
                compare_op(T_RESET, "mem_signal in reset", mem_signal, mem_nop);
            end
        end
        rst <= 1'b0;

        // fetch request already up in the first cycle out of reset
        @(posedge clk);
        compare_op(T_RESET, "mem_signal after reset", mem_signal, read_inst);

        while (fetches < NUM_FETCHES && !timed_out) begin
            ins = model_mem[model_pc[`MEM_ADDR_W-1:2]];
            serve_access((fetches == 0) ? T_RESET : (prev_jump ? T_JUMP : T_SEQ), read_inst,
                         model_pc[`MEM_ADDR_W-1:0], '0);
            fetches++;
            if (fetches == 1) begin
                report_test(T_RESET);
            end
            prev_jump = (ins[6:0] == 7'b1100011) || (ins[6:0] == 7'b1101111) ||
                        (ins[6:0] == 7'b1100111);
            model_step(ins, op, addr, wdata);
            if (op != mem_nop) begin
                serve_access((op == read_data) ? T_LOAD : T_STORE, op, addr, wdata);
            end
        end

        tot_chk = 0;
        tot_err = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (i != T_RESET) begin
                report_test(i);
            end
            tot_chk += checks[i];
            tot_err += errors[i];
        end
        $display("fetches %0d, checks %0d, errors %0d", fetches, tot_chk, tot_err);
        if (tot_err == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/cpu_pkg.sv
source/decoder.sv
source/imm_gen.sv
source/alu.sv
source/reg_file.sv
source/next_pc.sv
source/stage_sequencer.sv
source/cpu_top.sv
tests/tb_cpu.sv

/* Bender.yml */
package:
  name: rv32i_multicycle

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/decoder.sv
      - source/imm_gen.sv
      - source/alu.sv
      - source/reg_file.sv
      - source/next_pc.sv
      - source/stage_sequencer.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_cpu.sv
